// ==== include/laneAlign.svh ====
`ifndef LANE_ALIGN_SVH
`define LANE_ALIGN_SVH

// Byte enables for a store at the given byte offset
function automatic logic [3:0] storeByteEn(input memSysPkg::memOpT op, input logic [1:0] off);
   case (op)
      memSysPkg::opSb: return 4'b0001 << off;
      memSysPkg::opSh: return off[1] ? 4'b1100 : 4'b0011;
      default:         return 4'b1111;
   endcase
endfunction

// Replicate the low bytes so every enabled lane sees its data
function automatic logic [31:0] storeData(input memSysPkg::memOpT op, input logic [31:0] wdata);
   case (op)
      memSysPkg::opSb: return {4{wdata[7:0]}};
      memSysPkg::opSh: return {2{wdata[15:0]}};
      default:         return wdata;
   endcase
endfunction

// Pull the addressed lanes out of a word and extend them
function automatic logic [31:0] loadExtract(input memSysPkg::memOpT op, input logic [1:0] off,
                                            input logic [31:0] word);
   logic [7:0]  b;
   logic [15:0] h;
   b = word[off*8 +: 8];
   h = off[1] ? word[31:16] : word[15:0];
   case (op)
      memSysPkg::opLb:  return {{24{b[7]}}, b};
      memSysPkg::opLbu: return {24'b0, b};
      memSysPkg::opLh:  return {{16{h[15]}}, h};
      memSysPkg::opLhu: return {16'b0, h};
      default:          return word;
   endcase
endfunction

`endif

// ==== src/memSysPkg.sv ====
package memSysPkg;

   // Unified memory geometry
   localparam int MemWords = 1024;
   localparam int MemAddrBits = 10;

   // I/O region, selected by the top nibble of the address
   localparam logic [31:0] IoBase = 32'h8000_0000;

   // Graphics registers live outside IoBase but still decode as I/O
   localparam logic [31:0] GpCodeAddr = 32'h1800_0000;
   localparam logic [31:0] GpFrameAddr = 32'h1800_0004;

   localparam logic [31:0] CycleAddr = IoBase + 32'h10;
   localparam logic [31:0] InstrAddr = IoBase + 32'h14;
   localparam logic [31:0] FrameAddr = IoBase + 32'h18;
   localparam logic [31:0] CounterResetAddr = IoBase + 32'h1C;

   localparam logic [31:0] GpFrameReset = 32'h1040_0000;

   typedef enum logic [3:0] {
      opLb,
      opLbu,
      opLh,
      opLhu,
      opLw,
      opSb,
      opSh,
      opSw
   } memOpT;

   typedef enum logic [2:0] {
      gpCodeSel,
      gpFrameSel,
      cycleSel,
      instrSel,
      frameSel,
      counterResetSel,
      noneSel
   } ioSelT;

   // Command from the core on the data port
   typedef struct packed {
      memOpT       op;
      logic [31:0] addr;
      logic [31:0] wdata;
   } dataCmdT;

   // Word access to the unified memory
   typedef struct packed {
      logic                   write;
      logic [MemAddrBits-1:0] wordIdx;
      logic [3:0]             byteEn;
      logic [31:0]            wdata;
   } memReqT;

   typedef struct packed {
      logic        write;
      ioSelT       sel;
      logic [31:0] wdata;
   } ioReqT;

endpackage

// ==== src/unifiedMem.sv ====
`timescale 1ns/100ps

module unifiedMem (
   input  logic               clk,
   input  logic               memEn,
   input  memSysPkg::memReqT  memPortCmd,
   output logic [31:0]        rdata
);

   logic [31:0] mem [memSysPkg::MemWords];

   // Byte-lane writes and a registered read, old data on a write cycle
   always_ff @(posedge clk) begin
      if (memEn) begin
         for (int i = 0; i < 4; i++) begin
            if (memPortCmd.write && memPortCmd.byteEn[i]) begin
               mem[memPortCmd.wordIdx][i*8 +: 8] <= memPortCmd.wdata[i*8 +: 8];
            end
         end
         rdata <= mem[memPortCmd.wordIdx];
      end
   end

endmodule

// ==== src/mmioRegs.sv ====
`timescale 1ns/100ps

module mmioRegs (
   input  logic              clk,
   input  logic              reset,
   input  logic              ioReq,
   input  memSysPkg::ioReqT  ioCmd,
   output logic              ioAck,
   output logic [31:0]       ioRdata,
   input  logic              fetchAck,
   input  logic              frameTick,
   output logic [31:0]       gpCode,
   output logic [31:0]       gpFrame,
   output logic              gpValid
);

   logic [31:0] cycleCount;
   logic [31:0] instrCount;
   logic [31:0] frameCount;
   logic        fetchAckPrev;
   logic        ioStart;
   logic        ioWrite;

   // Side effects happen once, on the first cycle of a request
   assign ioStart = ioReq && !ioAck;
   assign ioWrite = ioStart && ioCmd.write;

   always_ff @(posedge clk) begin
      if (reset) begin
         ioAck <= 1'b0;
         fetchAckPrev <= 1'b0;
         cycleCount <= 32'b0;
         instrCount <= 32'b0;
         frameCount <= 32'b0;
         gpCode <= 32'b0;
         gpFrame <= memSysPkg::GpFrameReset;
         gpValid <= 1'b0;
      end else begin
         ioAck <= ioReq;
         fetchAckPrev <= fetchAck;
         gpValid <= ioWrite && (ioCmd.sel == memSysPkg::gpCodeSel);
         if (frameTick) begin
            frameCount <= frameCount + 32'd1;
         end
         if (ioWrite && ioCmd.sel == memSysPkg::counterResetSel) begin
            cycleCount <= 32'b0;
            instrCount <= 32'b0;
         end else begin
            cycleCount <= cycleCount + 32'd1;
            // Completed fetch = rising edge of fetchAck
            if (fetchAck && !fetchAckPrev) begin
               instrCount <= instrCount + 32'd1;
            end
         end
         if (ioWrite && ioCmd.sel == memSysPkg::gpCodeSel) begin
            gpCode <= ioCmd.wdata;
         end
         if (ioWrite && ioCmd.sel == memSysPkg::gpFrameSel) begin
            gpFrame <= ioCmd.wdata;
         end
      end
   end

   // Read value captured together with the ack
   always_ff @(posedge clk) begin
      if (ioStart) begin
         case (ioCmd.sel)
            memSysPkg::gpCodeSel:  ioRdata <= gpCode;
            memSysPkg::gpFrameSel: ioRdata <= gpFrame;
            memSysPkg::cycleSel:   ioRdata <= cycleCount;
            memSysPkg::instrSel:   ioRdata <= instrCount;
            memSysPkg::frameSel:   ioRdata <= frameCount;
            default:               ioRdata <= 32'b0;
         endcase
      end
   end

endmodule

// ==== src/memArbiter.sv ====
`timescale 1ns/100ps

module memArbiter (
   input  logic               clk,
   input  logic               reset,
   input  logic               memReq,
   input  memSysPkg::memReqT  memCmd,
   output logic               memAck,
   output logic [31:0]        memRdata,
   input  logic               fetchReq,
   input  logic [31:0]        fetchAddr,
   output logic               fetchAck,
   output logic [31:0]        fetchInstr,
   output logic               memEn,
   output memSysPkg::memReqT  memPortCmd,
   input  logic [31:0]        rdata
);

   typedef enum logic [1:0] {idle, access, hold} arbStateT;

   arbStateT           state;
   logic               grantFetch;
   logic               pickFetch;
   logic               ownerReq;
   memSysPkg::memReqT  fetchCmd;

   // Fetch is always a plain word read
   always_comb begin
      fetchCmd.write = 1'b0;
      fetchCmd.wordIdx = fetchAddr[memSysPkg::MemAddrBits+1:2];
      fetchCmd.byteEn = 4'b1111;
      fetchCmd.wdata = 32'b0;
   end

   // On a tie the peer not served last wins
   assign pickFetch = fetchReq && (!memReq || !grantFetch);
   assign ownerReq = grantFetch ? fetchReq : memReq;

   // Memory is issued straight from idle, so read data is ready in access
   assign memEn = (state == idle) && (memReq || fetchReq);
   assign memPortCmd = pickFetch ? fetchCmd : memCmd;

   always_ff @(posedge clk) begin
      if (reset) begin
         state <= idle;
         grantFetch <= 1'b0;
         memAck <= 1'b0;
         fetchAck <= 1'b0;
      end else begin
         case (state)
            idle: begin
               if (memReq || fetchReq) begin
                  grantFetch <= pickFetch;
                  state <= access;
               end
            end
            access: begin
               memAck <= !grantFetch;
               fetchAck <= grantFetch;
               state <= hold;
            end
            hold: begin
               // Grant stays until the owner drops req
               if (!ownerReq) begin
                  memAck <= 1'b0;
                  fetchAck <= 1'b0;
                  state <= idle;
               end
            end
            default: state <= idle;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (state == access) begin
         if (grantFetch) begin
            fetchInstr <= rdata;
         end else begin
            memRdata <= rdata;
         end
      end
   end

endmodule

// ==== src/dataPort.sv ====
`timescale 1ns/100ps

module dataPort (
   input  logic                clk,
   input  logic                reset,
   input  logic                dataReq,
   input  memSysPkg::dataCmdT  dataCmd,
   output logic                dataAck,
   output logic [31:0]         dataRdata,
   output logic                memReq,
   output memSysPkg::memReqT   memCmd,
   input  logic                memAck,
   input  logic [31:0]         memRdata,
   output logic                ioReq,
   output memSysPkg::ioReqT    ioCmd,
   input  logic                ioAck,
   input  logic [31:0]         ioRdata
);

   `include "laneAlign.svh"

   typedef enum logic [1:0] {idle, waitMem, waitIo, done} portStateT;

   portStateT           state;
   logic                isStore;
   logic                isIo;
   memSysPkg::ioSelT    ioSel;
   memSysPkg::memOpT    latchOp;
   logic [1:0]          latchOff;

   // Address decode
   always_comb begin
      isStore = dataCmd.op inside {memSysPkg::opSb, memSysPkg::opSh, memSysPkg::opSw};
      isIo = (dataCmd.addr[31:28] == memSysPkg::IoBase[31:28]) ||
             (dataCmd.addr == memSysPkg::GpCodeAddr) ||
             (dataCmd.addr == memSysPkg::GpFrameAddr);
      case (dataCmd.addr)
         memSysPkg::GpCodeAddr:       ioSel = memSysPkg::gpCodeSel;
         memSysPkg::GpFrameAddr:      ioSel = memSysPkg::gpFrameSel;
         memSysPkg::CycleAddr:        ioSel = memSysPkg::cycleSel;
         memSysPkg::InstrAddr:        ioSel = memSysPkg::instrSel;
         memSysPkg::FrameAddr:        ioSel = memSysPkg::frameSel;
         memSysPkg::CounterResetAddr: ioSel = memSysPkg::counterResetSel;
         default:                     ioSel = memSysPkg::noneSel;
      endcase
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         state <= idle;
         dataAck <= 1'b0;
         memReq <= 1'b0;
         ioReq <= 1'b0;
      end else begin
         case (state)
            idle: begin
               // Inner acks must be low before a new inner request
               if (dataReq && !memAck && !ioAck) begin
                  if (isIo) begin
                     ioReq <= 1'b1;
                     state <= waitIo;
                  end else begin
                     memReq <= 1'b1;
                     state <= waitMem;
                  end
               end
            end
            waitMem: begin
               if (memAck) begin
                  memReq <= 1'b0;
                  dataAck <= 1'b1;
                  state <= done;
               end
            end
            waitIo: begin
               if (ioAck) begin
                  ioReq <= 1'b0;
                  dataAck <= 1'b1;
                  state <= done;
               end
            end
            done: begin
               if (!dataReq) begin
                  dataAck <= 1'b0;
                  state <= idle;
               end
            end
            default: state <= idle;
         endcase
      end
   end

   // Payload follows the core while idle, then holds for the inner handshake
   always_ff @(posedge clk) begin
      if (state == idle) begin
         latchOp <= dataCmd.op;
         latchOff <= dataCmd.addr[1:0];
         memCmd.write <= isStore;
         memCmd.wordIdx <= dataCmd.addr[memSysPkg::MemAddrBits+1:2];
         memCmd.byteEn <= storeByteEn(dataCmd.op, dataCmd.addr[1:0]);
         memCmd.wdata <= storeData(dataCmd.op, dataCmd.wdata);
         ioCmd.write <= isStore;
         ioCmd.sel <= ioSel;
         ioCmd.wdata <= dataCmd.wdata;
      end
      if (state == waitMem && memAck) begin
         dataRdata <= loadExtract(latchOp, latchOff, memRdata);
      end
      // I/O reads are always full words
      if (state == waitIo && ioAck) begin
         dataRdata <= ioRdata;
      end
   end

endmodule

// ==== src/memSystem.sv ====
`timescale 1ns/100ps

module memSystem (
   input  logic                clk,
   input  logic                reset,
   input  logic                dataReq,
   input  memSysPkg::dataCmdT  dataCmd,
   output logic                dataAck,
   output logic [31:0]         dataRdata,
   input  logic                fetchReq,
   input  logic [31:0]         fetchAddr,
   output logic                fetchAck,
   output logic [31:0]         fetchInstr,
   input  logic                frameTick,
   output logic [31:0]         gpCode,
   output logic [31:0]         gpFrame,
   output logic                gpValid
);

   logic               memReq;
   memSysPkg::memReqT  memCmd;
   logic               memAck;
   logic [31:0]        memRdata;
   logic               ioReq;
   memSysPkg::ioReqT   ioCmd;
   logic               ioAck;
   logic [31:0]        ioRdata;
   logic               memEn;
   memSysPkg::memReqT  memPortCmd;
   logic [31:0]        rdata;

   dataPort u_dataPort (
      .clk(clk), .reset(reset),
      .dataReq(dataReq), .dataCmd(dataCmd), .dataAck(dataAck), .dataRdata(dataRdata),
      .memReq(memReq), .memCmd(memCmd), .memAck(memAck), .memRdata(memRdata),
      .ioReq(ioReq), .ioCmd(ioCmd), .ioAck(ioAck), .ioRdata(ioRdata)
   );

   // Data and fetch ports share the memory as peers
   memArbiter u_memArbiter (
      .clk(clk), .reset(reset),
      .memReq(memReq), .memCmd(memCmd), .memAck(memAck), .memRdata(memRdata),
      .fetchReq(fetchReq), .fetchAddr(fetchAddr), .fetchAck(fetchAck),
      .fetchInstr(fetchInstr),
      .memEn(memEn), .memPortCmd(memPortCmd), .rdata(rdata)
   );

   unifiedMem u_unifiedMem (
      .clk(clk), .memEn(memEn), .memPortCmd(memPortCmd), .rdata(rdata)
   );

   mmioRegs u_mmioRegs (
      .clk(clk), .reset(reset),
      .ioReq(ioReq), .ioCmd(ioCmd), .ioAck(ioAck), .ioRdata(ioRdata),
      .fetchAck(fetchAck), .frameTick(frameTick),
      .gpCode(gpCode), .gpFrame(gpFrame), .gpValid(gpValid)
   );

endmodule

// ==== bench/clockGen.sv ====
`timescale 1ns/100ps

module clockGen (
   output logic clk,
   output logic reset
);

   // 20 ns period
   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   // Reset held over the first 3 rising edges
   initial begin
      reset = 1'b1;
      repeat (3) @(posedge clk);
      #2;
      reset = 1'b0;
   end

endmodule

// ==== bench/memSystem_sva.sv ====
`timescale 1ns/100ps

module memSystem_sva (
   input logic                clk,
   input logic                reset,
   input logic                dataReq,
   input memSysPkg::dataCmdT  dataCmd,
   input logic                dataAck,
   input logic                fetchReq,
   input logic                fetchAck,
   input logic                memReq,
   input logic                memAck,
   input logic                ioReq,
   input logic                ioAck,
   input logic                gpValid
);

   // Ack only rises in answer to a req seen high the cycle before
   dataAckNeedsReq: assert property (@(posedge clk) disable iff (reset)
      $rose(dataAck) |-> $past(dataReq)) else $error("dataAck rose without dataReq");
   fetchAckNeedsReq: assert property (@(posedge clk) disable iff (reset)
      $rose(fetchAck) |-> $past(fetchReq)) else $error("fetchAck rose without fetchReq");
   memAckNeedsReq: assert property (@(posedge clk) disable iff (reset)
      $rose(memAck) |-> $past(memReq)) else $error("memAck rose without memReq");
   ioAckNeedsReq: assert property (@(posedge clk) disable iff (reset)
      $rose(ioAck) |-> $past(ioReq)) else $error("ioAck rose without ioReq");

   // Req held until the responder acks
   dataReqHeld: assert property (@(posedge clk) disable iff (reset)
      dataReq && !dataAck |=> (dataReq || dataAck))
      else $error("dataReq dropped before dataAck");
   fetchReqHeld: assert property (@(posedge clk) disable iff (reset)
      fetchReq && !fetchAck |=> (fetchReq || fetchAck))
      else $error("fetchReq dropped before fetchAck");
   memReqHeld: assert property (@(posedge clk) disable iff (reset)
      memReq && !memAck |=> (memReq || memAck))
      else $error("memReq dropped before memAck");
   ioReqHeld: assert property (@(posedge clk) disable iff (reset)
      ioReq && !ioAck |=> (ioReq || ioAck))
      else $error("ioReq dropped before ioAck");

   dataCmdStable: assert property (@(posedge clk) disable iff (reset)
      dataReq && $past(dataReq) |-> $stable(dataCmd))
      else $error("dataCmd changed while dataReq was high");

   // Single-cycle strobe
   gpValidPulse: assert property (@(posedge clk) disable iff (reset)
      gpValid |=> !gpValid) else $error("gpValid stayed high for two cycles");

endmodule

// ==== bench/tbMemSystem.sv ====
`timescale 1ns/100ps

module tbMemSystem;

   localparam int NumWords = 16;
   localparam int NumConc = 8;
   localparam int NumTicks = 7;
   // Graphics, words, lanes, concurrent and counter tests in that order
   localparam int TotalXfers = 5 + (2 * NumWords + 3) + 37 + 3 * NumConc + 7;
   localparam logic [31:0] LaneBase = 32'h0000_0800;
   localparam logic [31:0] ConcBase = 32'h0000_0C00;

   logic                clk;
   logic                reset;
   logic                dataReq;
   memSysPkg::dataCmdT  dataCmd;
   logic                dataAck;
   logic [31:0]         dataRdata;
   logic                fetchReq;
   logic [31:0]         fetchAddr;
   logic                fetchAck;
   logic [31:0]         fetchInstr;
   logic                frameTick;
   logic [31:0]         gpCode;
   logic [31:0]         gpFrame;
   logic                gpValid;

   integer      seed = 32'h0c8d_b34f;
   int          fetchTotal = 0;
   int          gpValidCount = 0;
   logic [31:0] wordModel [int];
   logic [31:0] wordAddrs [$];

   clockGen u_clockGen (.clk(clk), .reset(reset));

   memSystem u_memSystem (
      .clk(clk), .reset(reset),
      .dataReq(dataReq), .dataCmd(dataCmd), .dataAck(dataAck), .dataRdata(dataRdata),
      .fetchReq(fetchReq), .fetchAddr(fetchAddr), .fetchAck(fetchAck),
      .fetchInstr(fetchInstr), .frameTick(frameTick),
      .gpCode(gpCode), .gpFrame(gpFrame), .gpValid(gpValid)
   );

   bind memSystem memSystem_sva u_memSystemSva (
      .clk(clk), .reset(reset),
      .dataReq(dataReq), .dataCmd(dataCmd), .dataAck(dataAck),
      .fetchReq(fetchReq), .fetchAck(fetchAck),
      .memReq(memReq), .memAck(memAck), .ioReq(ioReq), .ioAck(ioAck),
      .gpValid(gpValid)
   );

   // Pulses counted mid-cycle
   always @(negedge clk) begin
      if (gpValid) begin
         gpValidCount++;
      end
   end

   task automatic checkEq(input string testName, input logic [31:0] expected,
                          input logic [31:0] actual);
      if (actual !== expected) begin
         $display("ERROR %s: expected %h, actual %h", testName, expected, actual);
         $display(">>> FAIL");
         $fatal(1, "Value mismatch in %s", testName);
      end
   endtask

   task automatic stepCycle();
      @(posedge clk);
      #2;
   endtask

   // Word index is address bits 11 down to 2
   function automatic int wordIndex(input logic [31:0] addr);
      return int'(addr[11:2]);
   endfunction

   task automatic dataAccess(input memSysPkg::memOpT op, input logic [31:0] addr,
                             input logic [31:0] wdata, output logic [31:0] rdata);
      stepCycle();
      dataCmd.op = op;
      dataCmd.addr = addr;
      dataCmd.wdata = wdata;
      dataReq = 1'b1;
      do begin
         stepCycle();
      end while (!dataAck);
      rdata = dataRdata;
      dataReq = 1'b0;
      do begin
         stepCycle();
      end while (dataAck);
   endtask

   task automatic fetchAccess(input logic [31:0] addr, output logic [31:0] instr);
      stepCycle();
      fetchAddr = addr;
      fetchReq = 1'b1;
      do begin
         stepCycle();
      end while (!fetchAck);
      instr = fetchInstr;
      fetchReq = 1'b0;
      do begin
         stepCycle();
      end while (fetchAck);
      fetchTotal++;
   endtask

   task automatic testGraphics();
      logic [31:0] rd;
      logic [31:0] code;
      logic [31:0] frame;
      int          pulses;
      code = $random(seed);
      frame = $random(seed);
      checkEq("gp code reset", 32'h0, gpCode);
      dataAccess(memSysPkg::opLw, memSysPkg::GpFrameAddr, 32'h0, rd);
      checkEq("gp frame reset", memSysPkg::GpFrameReset, rd);
      pulses = gpValidCount;
      dataAccess(memSysPkg::opSw, memSysPkg::GpCodeAddr, code, rd);
      checkEq("gp code output", code, gpCode);
      checkEq("gp valid after code", 32'(pulses + 1), 32'(gpValidCount));
      dataAccess(memSysPkg::opSw, memSysPkg::GpFrameAddr, frame, rd);
      checkEq("gp frame output", frame, gpFrame);
      checkEq("gp valid after frame", 32'(pulses + 1), 32'(gpValidCount));
      dataAccess(memSysPkg::opLw, memSysPkg::GpCodeAddr, 32'h0, rd);
      checkEq("gp code readback", code, rd);
      dataAccess(memSysPkg::opLw, memSysPkg::GpFrameAddr, 32'h0, rd);
      checkEq("gp frame readback", frame, rd);
   endtask

   task automatic testWords();
      logic [31:0] addr;
      logic [31:0] data;
      logic [31:0] rd;
      for (int i = 0; i < NumWords; i++) begin
         // Plain memory, lower half of the word range
         addr = $random(seed);
         addr[31:28] = 4'h0;
         addr[11] = 1'b0;
         addr[1:0] = 2'b00;
         data = $random(seed);
         dataAccess(memSysPkg::opSw, addr, data, rd);
         wordModel[wordIndex(addr)] = data;
         wordAddrs.push_back(addr);
      end
      foreach (wordAddrs[i]) begin
         dataAccess(memSysPkg::opLw, wordAddrs[i], 32'h0, rd);
         checkEq("word readback", wordModel[wordIndex(wordAddrs[i])], rd);
      end
      // Upper address bits are ignored
      addr = wordAddrs[0] ^ 32'h0040_0000;
      data = $random(seed);
      dataAccess(memSysPkg::opSw, addr, data, rd);
      wordModel[wordIndex(addr)] = data;
      dataAccess(memSysPkg::opLw, wordAddrs[0], 32'h0, rd);
      checkEq("alias overwrite", data, rd);
      dataAccess(memSysPkg::opLw, addr, 32'h0, rd);
      checkEq("alias readback", data, rd);
   endtask

   task automatic checkLoads(input logic [31:0] word);
      logic [31:0] rd;
      for (int off = 0; off < 4; off++) begin
         dataAccess(memSysPkg::opLb, LaneBase + 32'(off), 32'h0, rd);
         checkEq("load byte signed", 32'($signed(word[off*8 +: 8])), rd);
         dataAccess(memSysPkg::opLbu, LaneBase + 32'(off), 32'h0, rd);
         checkEq("load byte unsigned", 32'(word[off*8 +: 8]), rd);
      end
      for (int off = 0; off < 4; off += 2) begin
         dataAccess(memSysPkg::opLh, LaneBase + 32'(off), 32'h0, rd);
         checkEq("load half signed", 32'($signed(word[off*8 +: 16])), rd);
         dataAccess(memSysPkg::opLhu, LaneBase + 32'(off), 32'h0, rd);
         checkEq("load half unsigned", 32'(word[off*8 +: 16]), rd);
      end
   endtask

   task automatic testLanes();
      logic [31:0] word;
      logic [31:0] data;
      logic [31:0] rd;
      // Mix of lanes with and without the top bit set
      word = 32'h80ff_7f01;
      dataAccess(memSysPkg::opSw, LaneBase, word, rd);
      checkLoads(word);
      for (int off = 0; off < 4; off++) begin
         data = $random(seed);
         dataAccess(memSysPkg::opSb, LaneBase + 32'(off), data, rd);
         word[off*8 +: 8] = data[7:0];
         dataAccess(memSysPkg::opLw, LaneBase, 32'h0, rd);
         checkEq("store byte lanes", word, rd);
      end
      for (int off = 0; off < 4; off += 2) begin
         data = $random(seed);
         dataAccess(memSysPkg::opSh, LaneBase + 32'(off), data, rd);
         word[off*8 +: 16] = data[15:0];
         dataAccess(memSysPkg::opLw, LaneBase, 32'h0, rd);
         checkEq("store half lanes", word, rd);
      end
      checkLoads(word);
   endtask

   task automatic testConcurrent();
      logic [31:0] concData [NumConc];
      logic [31:0] instr;
      logic [31:0] rd;
      for (int i = 0; i < NumConc; i++) begin
         concData[i] = $random(seed);
      end
      // Stores and fetches touch different words while both run
      fork
         begin
            for (int i = 0; i < NumConc; i++) begin
               dataAccess(memSysPkg::opSw, ConcBase + 32'(4 * i), concData[i], rd);
            end
         end
         begin
            for (int i = 0; i < NumConc; i++) begin
               fetchAccess(wordAddrs[i], instr);
               checkEq("fetch during stores", wordModel[wordIndex(wordAddrs[i])], instr);
            end
         end
      join
      for (int i = 0; i < NumConc; i++) begin
         fetchAccess(ConcBase + 32'(4 * i), instr);
         checkEq("fetch after stores", concData[i], instr);
      end
   endtask

   task automatic testCounters();
      logic [31:0] rd;
      logic [31:0] cycleA;
      logic [31:0] cycleB;
      stepCycle();
      frameTick = 1'b1;
      repeat (NumTicks) stepCycle();
      frameTick = 1'b0;
      dataAccess(memSysPkg::opLw, memSysPkg::FrameAddr, 32'h0, rd);
      checkEq("frame count", 32'(NumTicks), rd);
      dataAccess(memSysPkg::opLw, memSysPkg::InstrAddr, 32'h0, rd);
      checkEq("instr count", 32'(fetchTotal), rd);
      dataAccess(memSysPkg::opLw, memSysPkg::CycleAddr, 32'h0, cycleA);
      dataAccess(memSysPkg::opLw, memSysPkg::CycleAddr, 32'h0, cycleB);
      checkEq("cycle count rises", 32'd1, 32'(cycleB > cycleA));
      dataAccess(memSysPkg::opSw, memSysPkg::CounterResetAddr, 32'h0, rd);
      dataAccess(memSysPkg::opLw, memSysPkg::InstrAddr, 32'h0, rd);
      checkEq("instr count cleared", 32'h0, rd);
      dataAccess(memSysPkg::opLw, memSysPkg::CycleAddr, 32'h0, rd);
      checkEq("cycle count cleared", 32'd1, 32'(rd < cycleB));
   endtask

   initial begin
      dataReq = 1'b0;
      dataCmd = '0;
      fetchReq = 1'b0;
      fetchAddr = 32'h0;
      frameTick = 1'b0;
      wait (!reset);
      // Graphics first so the reset values are still in place
      testGraphics();
      testWords();
      testLanes();
      testConcurrent();
      testCounters();
      $display(">>> PASS");
      $finish;
   end

   // About 200 cycles per transaction
   initial begin
      repeat (TotalXfers * 200) @(posedge clk);
      $display(">>> FAIL");
      $fatal(1, "Timeout: the tests did not finish within %0d cycles", TotalXfers * 200);
   end

endmodule

// ==== flist.f ====
+incdir+include
src/memSysPkg.sv
src/unifiedMem.sv
src/mmioRegs.sv
src/memArbiter.sv
src/dataPort.sv
src/memSystem.sv
bench/clockGen.sv
bench/memSystem_sva.sv
bench/tbMemSystem.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the memory system testbench with Verilator.
# The exit status is the simulator's: nonzero on any failure.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
   --top-module tbMemSystem \
   -f flist.f \
   -o simMemSystem
status=$?
if [ $status -ne 0 ]; then
   echo "Verilator build failed"
   exit $status
fi

./obj_dir/simMemSystem
status=$?
if [ $status -ne 0 ]; then
   echo "Simulation failed"
   exit $status
fi

exit 0
